// ==== hdl/cache_ctrl_pkg.sv ====
package cache_ctrl_pkg;

	localparam int num_executers = 4;
	localparam int lane_words = 8; // 16-bit words per cache lane

	typedef logic [1:0] exec_idx_t;
	typedef logic [15:0] stack_addr_t;
	typedef logic [31:0] general_addr_t;
	typedef logic [25:0] way_addr_t;
	typedef logic [5:0] upper_addr_t; // non-zero selects I/O space
	typedef logic [2:0] stack_size_t; // in 16-bit words

	typedef enum logic [2:0] {
		ph_idle = 3'd0,
		ph_stack_first = 3'd1, // lane-crossing stack, first lane
		ph_stack_second = 3'd2, // lane-crossing stack, second lane
		ph_stack_single = 3'd3,
		ph_general = 3'd4,
		ph_ifetch = 3'd5
	} access_phase_e;

	typedef enum logic [1:0] {
		kind_none = 2'd0,
		kind_stack = 2'd1,
		kind_general = 2'd2,
		kind_ifetch = 2'd3
	} access_kind_e;

	typedef enum logic [1:0] {
		mask_first = 2'd0,
		mask_second = 2'd1,
		mask_general = 2'd2,
		mask_none = 2'd3
	} mask_type_e;

	typedef struct packed {
		logic stack_req;
		logic general_req;
		logic stack_write;
		logic general_write;
		logic general_byte;
		stack_size_t stack_size;
		stack_addr_t stack_addr;
		general_addr_t general_addr;
	} exec_req_t;

	typedef struct packed {
		access_kind_e kind;
		exec_idx_t index;
		logic multi_lane; // stack access spills into the next lane
	} grant_t;

	typedef struct packed {
		way_addr_t way_addr;
		upper_addr_t upper_addr;
		logic byte_op;
		logic partial_write;
		stack_size_t stack_size;
		exec_idx_t index;
		logic use_multi_access;
	} cache_access_t;

	typedef struct packed {
		logic [num_executers-1:0] executer_ack;
		logic ifetch_ack;
		logic [num_executers-1:0] dependency_clear;
		logic lru_enable_write;
		logic cache_no_write_override;
		mask_type_e mask_type;
		logic cache_fault;
	} ctrl_status_t;

endpackage

// ==== hdl/access_arbiter.sv ====
`timescale 1ns/1ps

module access_arbiter
	import cache_ctrl_pkg::*;
(
	input exec_req_t [num_executers-1:0] exec_req,
	input logic ifetch_req,
	input logic new_access_allowed,
	input access_kind_e excluded_kind,
	input exec_idx_t excluded_index,
	output grant_t grant
);

	logic [num_executers-1:0] stack_ok; // requesting and not just served
	logic [num_executers-1:0] general_ok;
	logic [num_executers-1:0] crossing;
	logic [3:0] lane_sum [num_executers];
	logic ifetch_ok;

	for (genvar i = 0; i < num_executers; i++) begin : g_req
		assign stack_ok[i] = exec_req[i].stack_req &&
			!(excluded_kind == kind_stack && excluded_index == exec_idx_t'(i));
		assign general_ok[i] = exec_req[i].general_req &&
			!(excluded_kind == kind_general && excluded_index == exec_idx_t'(i));
		// word offset in the lane plus size, past the lane end means two passes
		assign lane_sum[i] = {1'b0, exec_req[i].stack_addr[3:1]} +
			{1'b0, exec_req[i].stack_size};
		assign crossing[i] = lane_sum[i] > 4'(lane_words);
	end

	assign ifetch_ok = ifetch_req && excluded_kind != kind_ifetch;

	// stack i beats general i, lower executers first, ifetch last
	always_comb begin
		grant = '0;
		grant.kind = kind_none;
		if (new_access_allowed) begin
			for (int i = 0; i < num_executers; i++) begin
				if (grant.kind == kind_none) begin
					if (stack_ok[i]) begin
						grant.kind = kind_stack;
						grant.index = exec_idx_t'(i);
						grant.multi_lane = crossing[i];
					end else if (general_ok[i]) begin
						grant.kind = kind_general;
						grant.index = exec_idx_t'(i);
					end
				end
			end
			if (grant.kind == kind_none && ifetch_ok) begin
				grant.kind = kind_ifetch; // index stays 0
			end
		end
	end

endmodule

// ==== hdl/access_sequencer.sv ====
`timescale 1ns/1ps

module access_sequencer
	import cache_ctrl_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic raw_cache_fault,
	input exec_req_t [num_executers-1:0] exec_req,
	input grant_t grant,
	output logic new_access_allowed,
	output access_kind_e excluded_kind,
	output exec_idx_t excluded_index,
	output access_phase_e next_phase,
	output exec_idx_t next_index,
	output ctrl_status_t status
);

	access_phase_e phase_q;
	exec_idx_t index_q;
	upper_addr_t upper_q; // upper address of the general access in flight

	logic io_bypass;
	logic mask_fault;
	logic cache_fault;
	logic take_grant;

	// I/O space is handled outside the cache, faults mean nothing there
	assign io_bypass = phase_q == ph_general && upper_q != '0;
	assign mask_fault = phase_q == ph_idle || io_bypass;
	assign cache_fault = raw_cache_fault && !mask_fault;

	assign take_grant = new_access_allowed && grant.kind != kind_none;

	always_comb begin
		next_phase = phase_q; // hold while faulted
		next_index = index_q;
		new_access_allowed = 1'b0;
		excluded_kind = kind_none;
		excluded_index = index_q;
		status = '0;
		status.mask_type = mask_none;
		status.cache_fault = cache_fault;

		unique case (phase_q)
			ph_idle: begin
				new_access_allowed = 1'b1;
			end
			ph_stack_first: begin
				excluded_kind = kind_stack;
				status.mask_type = mask_first;
				if (!cache_fault) begin
					status.lru_enable_write = 1'b1;
					next_phase = ph_stack_second; // same executer, next lane
				end
			end
			ph_stack_second: begin
				excluded_kind = kind_stack;
				status.mask_type = mask_second;
				if (!cache_fault) begin
					new_access_allowed = 1'b1;
					status.executer_ack[index_q] = 1'b1;
					status.lru_enable_write = 1'b1;
					next_phase = ph_idle;
				end
			end
			ph_stack_single: begin
				excluded_kind = kind_stack;
				status.mask_type = mask_first;
				if (!cache_fault) begin
					new_access_allowed = 1'b1;
					status.executer_ack[index_q] = 1'b1;
					status.lru_enable_write = 1'b1;
					next_phase = ph_idle;
				end
			end
			ph_general: begin
				excluded_kind = kind_general;
				status.mask_type = mask_general;
				if (io_bypass) begin
					// completes at once, cache must not be written
					new_access_allowed = 1'b1;
					status.executer_ack[index_q] = 1'b1;
					status.cache_no_write_override = 1'b1;
					next_phase = ph_idle;
				end else if (!cache_fault) begin
					new_access_allowed = 1'b1;
					status.executer_ack[index_q] = 1'b1;
					status.lru_enable_write = 1'b1;
					next_phase = ph_idle;
				end
			end
			ph_ifetch: begin
				excluded_kind = kind_ifetch;
				if (!cache_fault) begin
					new_access_allowed = 1'b1;
					status.ifetch_ack = 1'b1;
					status.lru_enable_write = 1'b1;
					next_phase = ph_idle;
				end
			end
			default: begin
				next_phase = ph_idle;
			end
		endcase

		// chain the granted access straight after the completing one
		if (take_grant) begin
			next_index = grant.index;
			unique case (grant.kind)
				kind_stack: begin
					next_phase = grant.multi_lane ? ph_stack_first : ph_stack_single;
					status.dependency_clear[grant.index] = 1'b1;
				end
				kind_general: begin
					next_phase = ph_general;
					status.dependency_clear[grant.index] = 1'b1;
				end
				kind_ifetch: begin
					next_phase = ph_ifetch;
				end
				default: begin
					next_phase = ph_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			phase_q <= ph_idle;
			index_q <= '0;
			upper_q <= '0;
		end else begin
			phase_q <= next_phase;
			index_q <= next_index;
			if (take_grant && grant.kind == kind_general) begin
				upper_q <= exec_req[grant.index].general_addr[31:26];
			end
		end
	end

endmodule

// ==== hdl/way_address_select.sv ====
`timescale 1ns/1ps

module way_address_select
	import cache_ctrl_pkg::*;
(
	input access_phase_e next_phase,
	input exec_idx_t next_index,
	input exec_req_t [num_executers-1:0] exec_req,
	input way_addr_t ifetch_addr,
	output cache_access_t cache_access
);

	exec_req_t sel_req;
	stack_size_t size_less_one;
	stack_addr_t second_lane_addr;
	stack_addr_t stack_addr_eff;

	assign sel_req = exec_req[next_index];

	// second pass starts at the last word touched, wraps in 16 bits
	assign size_less_one = sel_req.stack_size - 3'd1;
	assign second_lane_addr = sel_req.stack_addr + {size_less_one, 1'b0};
	assign stack_addr_eff = (next_phase == ph_stack_second) ?
		second_lane_addr : sel_req.stack_addr;

	always_comb begin
		cache_access = '0;

		unique case (next_phase)
			ph_idle: begin
				cache_access.way_addr = ifetch_addr; // nothing to fetch, keep ifetch line
			end
			ph_stack_first, ph_stack_second, ph_stack_single: begin
				cache_access.way_addr = way_addr_t'(stack_addr_eff); // stack space sits low
				cache_access.way_addr[0] = 1'b0;
				cache_access.stack_size = sel_req.stack_size;
				cache_access.partial_write = sel_req.stack_write;
				cache_access.index = next_index;
				cache_access.use_multi_access = next_phase != ph_stack_single;
			end
			ph_general: begin
				cache_access.way_addr = sel_req.general_addr[25:0];
				cache_access.upper_addr = sel_req.general_addr[31:26];
				cache_access.byte_op = sel_req.general_byte;
				cache_access.partial_write = sel_req.general_write;
				cache_access.index = next_index;
			end
			ph_ifetch: begin
				cache_access.way_addr = ifetch_addr;
				cache_access.way_addr[0] = 1'b0; // word aligned
			end
			default: begin
				cache_access.way_addr = ifetch_addr;
			end
		endcase
	end

endmodule

// ==== hdl/split_cache_controller.sv ====
`timescale 1ns/1ps

module split_cache_controller
	import cache_ctrl_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input exec_req_t [num_executers-1:0] exec_req,
	input logic ifetch_req,
	input way_addr_t ifetch_addr,
	input logic raw_cache_fault,
	output cache_access_t cache_access,
	output ctrl_status_t status
);

	grant_t grant;
	logic new_access_allowed;
	access_kind_e excluded_kind;
	exec_idx_t excluded_index;
	access_phase_e next_phase; // look-ahead phase drives the way address
	exec_idx_t next_index;

	access_arbiter u_access_arbiter (
		.exec_req (exec_req),
		.ifetch_req (ifetch_req),
		.new_access_allowed (new_access_allowed),
		.excluded_kind (excluded_kind),
		.excluded_index (excluded_index),
		.grant (grant)
	);

	access_sequencer u_access_sequencer (
		.clk (clk),
		.arst_n (arst_n),
		.raw_cache_fault (raw_cache_fault),
		.exec_req (exec_req),
		.grant (grant),
		.new_access_allowed (new_access_allowed),
		.excluded_kind (excluded_kind),
		.excluded_index (excluded_index),
		.next_phase (next_phase),
		.next_index (next_index),
		.status (status)
	);

	way_address_select u_way_address_select (
		.next_phase (next_phase),
		.next_index (next_index),
		.exec_req (exec_req),
		.ifetch_addr (ifetch_addr),
		.cache_access (cache_access)
	);

endmodule

// ==== dv/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

function automatic logic io_bypass_on(input access_phase_e ph, input upper_addr_t up);
	return ph == ph_general && up != '0; // I/O space ignores the cache
endfunction

// current phase ends this cycle
function automatic logic phase_finishes(input access_phase_e ph, input upper_addr_t up,
		input logic raw);
	if (ph == ph_idle)
		return 1'b0;
	return io_bypass_on(ph, up) || !raw;
endfunction

function automatic access_kind_e kind_in_flight(input access_phase_e ph);
	case (ph)
		ph_stack_first, ph_stack_second, ph_stack_single: return kind_stack;
		ph_general: return kind_general;
		ph_ifetch: return kind_ifetch;
		default: return kind_none;
	endcase
endfunction

// slot order s0 g0 s1 g1 ... g3, then ifetch
function automatic grant_t predict_grant(input exec_req_t [num_executers-1:0] req,
		input logic ifr, input access_phase_e ph, input exec_idx_t idx,
		input upper_addr_t up, input logic raw);
	grant_t g;
	access_kind_e busy;
	access_kind_e k;
	logic want;
	int i;
	g = '0;
	g.kind = kind_none;
	busy = kind_in_flight(ph);
	if (ph != ph_idle && !(phase_finishes(ph, up, raw) && ph != ph_stack_first))
		return g; // still busy, or first lane leads into the second
	for (int slot = 0; slot < 2 * num_executers; slot++) begin
		i = slot / 2;
		if (slot % 2 == 0) begin
			k = kind_stack;
			want = req[i].stack_req;
		end else begin
			k = kind_general;
			want = req[i].general_req;
		end
		if (g.kind == kind_none && want && !(k == busy && exec_idx_t'(i) == idx)) begin
			g.kind = k;
			g.index = exec_idx_t'(i);
			g.multi_lane = k == kind_stack &&
				int'(req[i].stack_addr[3:1]) + int'(req[i].stack_size) > lane_words;
		end
	end
	if (g.kind == kind_none && ifr && busy != kind_ifetch)
		g.kind = kind_ifetch;
	return g;
endfunction

function automatic access_phase_e predict_phase(input access_phase_e ph, input logic done,
		input grant_t g);
	if (g.kind == kind_stack) begin
		if (g.multi_lane)
			return ph_stack_first;
		return ph_stack_single;
	end
	if (g.kind == kind_general)
		return ph_general;
	if (g.kind == kind_ifetch)
		return ph_ifetch;
	if (!done)
		return ph; // fault stall
	if (ph == ph_stack_first)
		return ph_stack_second;
	return ph_idle;
endfunction

function automatic ctrl_status_t expected_status(input access_phase_e ph, input exec_idx_t idx,
		input upper_addr_t up, input logic raw, input grant_t g);
	ctrl_status_t st;
	logic done;
	st = '0;
	done = phase_finishes(ph, up, raw);
	case (ph)
		ph_stack_first, ph_stack_single: st.mask_type = mask_first;
		ph_stack_second: st.mask_type = mask_second;
		ph_general: st.mask_type = mask_general;
		default: st.mask_type = mask_none;
	endcase
	st.cache_fault = raw && ph != ph_idle && !io_bypass_on(ph, up);
	if (done && ph == ph_ifetch)
		st.ifetch_ack = 1'b1;
	else if (done && ph != ph_stack_first)
		st.executer_ack[idx] = 1'b1;
	st.lru_enable_write = done && !io_bypass_on(ph, up);
	st.cache_no_write_override = io_bypass_on(ph, up);
	if (g.kind == kind_stack || g.kind == kind_general)
		st.dependency_clear[g.index] = 1'b1;
	return st;
endfunction

// look-ahead, built from the phase about to be entered
function automatic cache_access_t predict_access(input access_phase_e nph,
		input exec_idx_t nidx, input exec_req_t [num_executers-1:0] req,
		input way_addr_t ifa);
	cache_access_t ca;
	exec_req_t r;
	stack_addr_t a;
	ca = '0;
	r = req[nidx];
	case (nph)
		ph_stack_first, ph_stack_second, ph_stack_single: begin
			a = r.stack_addr;
			if (nph == ph_stack_second)
				a = a + stack_addr_t'(2 * (int'(r.stack_size) - 1));
			ca.way_addr = {10'd0, a[15:1], 1'b0};
			ca.stack_size = r.stack_size;
			ca.partial_write = r.stack_write;
			ca.index = nidx;
			ca.use_multi_access = nph != ph_stack_single;
		end
		ph_general: begin
			ca.way_addr = r.general_addr[25:0];
			ca.upper_addr = r.general_addr[31:26];
			ca.byte_op = r.general_byte;
			ca.partial_write = r.general_write;
			ca.index = nidx;
		end
		ph_ifetch: ca.way_addr = {ifa[25:1], 1'b0};
		default: ca.way_addr = ifa;
	endcase
	return ca;
endfunction

`endif

// ==== dv/tb_split_cache_controller.sv ====
`timescale 1ns/1ps

module tb_split_cache_controller
	import cache_ctrl_pkg::*;
();

	logic clk;
	logic arst_n;
	exec_req_t [num_executers-1:0] exec_req;
	logic ifetch_req;
	way_addr_t ifetch_addr;
	logic raw_cache_fault;
	cache_access_t cache_access;
	ctrl_status_t status;

	access_phase_e m_phase; // model state for the next cycle
	exec_idx_t m_index;
	upper_addr_t m_upper;
	ctrl_status_t seen_status; // outputs of the cycle just compared
	access_kind_e seen_kind; // kind of the access in that cycle
	logic [31:0] rng_state;
	int ack_count;

	`include "tb_ref_model.svh"

	split_cache_controller u_split_cache_controller (
		.clk (clk),
		.arst_n (arst_n),
		.exec_req (exec_req),
		.ifetch_req (ifetch_req),
		.ifetch_addr (ifetch_addr),
		.raw_cache_fault (raw_cache_fault),
		.cache_access (cache_access),
		.status (status)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic logic [31:0] draw_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	task automatic check_field(input string name, input logic [63:0] actual,
			input logic [63:0] expected);
		if (actual !== expected) begin
			$display("FAIL at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
			$display("Test failed");
			$fatal(1, "output mismatch");
		end
	endtask

	task automatic wait_ack(input logic is_ifetch, input int idx, input int limit);
		int waited;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
			if (waited > limit) begin
				$display("timeout: no acknowledge within %0d cycles", limit);
				$display("Test failed");
				$fatal(1, "acknowledge timeout");
			end
		end while (is_ifetch ? !status.ifetch_ack : !status.executer_ack[idx]);
	endtask

	// requests are held until acknowledged and fields change only while idle
	task automatic drive_random();
		logic [31:0] r;
		logic [31:0] r2;
		for (int i = 0; i < num_executers; i++) begin
			r = draw_random();
			r2 = draw_random();
			if (seen_status.executer_ack[i]) begin
				if (seen_kind == kind_stack)
					exec_req[i].stack_req <= 1'b0;
				else
					exec_req[i].general_req <= 1'b0;
			end else if (!exec_req[i].stack_req && !exec_req[i].general_req &&
					r[1:0] == 2'b00) begin
				exec_req[i].stack_addr <= r[31:16];
				exec_req[i].stack_size <= r[4:2];
				exec_req[i].stack_write <= r[5];
				exec_req[i].general_write <= r[6];
				exec_req[i].general_byte <= r[7];
				exec_req[i].general_addr <= {r[8] ? r2[31:26] : 6'h00, r2[25:0]}; // half I/O
				exec_req[i].stack_req <= r[9] | r[10]; // both kinds at once now and then
				exec_req[i].general_req <= !r[9];
			end
		end
		r = draw_random();
		if (seen_status.ifetch_ack) begin
			ifetch_req <= 1'b0;
		end else if (!ifetch_req) begin
			ifetch_addr <= r[25:0];
			ifetch_req <= r[26] & r[27];
		end
		raw_cache_fault <= r[31:30] == 2'b00;
	endtask

	always @(negedge clk) begin : compare_outputs
		grant_t g;
		ctrl_status_t exp_st;
		cache_access_t exp_acc;
		access_phase_e nph;
		exec_idx_t nidx;
		if (!arst_n) begin
			m_phase = ph_idle;
			m_index = '0;
			m_upper = '0;
			seen_status = '0;
			seen_kind = kind_none;
		end else begin
			g = predict_grant(exec_req, ifetch_req, m_phase, m_index, m_upper, raw_cache_fault);
			exp_st = expected_status(m_phase, m_index, m_upper, raw_cache_fault, g);
			nph = predict_phase(m_phase, phase_finishes(m_phase, m_upper, raw_cache_fault), g);
			nidx = (g.kind != kind_none) ? g.index : m_index;
			exp_acc = predict_access(nph, nidx, exec_req, ifetch_addr);
			check_field("executer_ack", status.executer_ack, exp_st.executer_ack);
			check_field("ifetch_ack", status.ifetch_ack, exp_st.ifetch_ack);
			check_field("dependency_clear", status.dependency_clear, exp_st.dependency_clear);
			check_field("lru_enable_write", status.lru_enable_write, exp_st.lru_enable_write);
			check_field("cache_no_write_override", status.cache_no_write_override,
				exp_st.cache_no_write_override);
			check_field("mask_type", status.mask_type, exp_st.mask_type);
			check_field("cache_fault", status.cache_fault, exp_st.cache_fault);
			check_field("way_addr", cache_access.way_addr, exp_acc.way_addr);
			check_field("upper_addr", cache_access.upper_addr, exp_acc.upper_addr);
			check_field("byte_op", cache_access.byte_op, exp_acc.byte_op);
			check_field("partial_write", cache_access.partial_write, exp_acc.partial_write);
			check_field("stack_size", cache_access.stack_size, exp_acc.stack_size);
			check_field("index", cache_access.index, exp_acc.index);
			check_field("use_multi_access", cache_access.use_multi_access,
				exp_acc.use_multi_access);
			ack_count += $countones(status.executer_ack) + int'(status.ifetch_ack);
			seen_status = status;
			seen_kind = kind_in_flight(m_phase);
			if (g.kind == kind_general)
				m_upper = exec_req[g.index].general_addr[31:26];
			m_phase = nph;
			m_index = nidx;
		end
	end

	initial begin
		arst_n = 1'b0;
		exec_req = '0;
		ifetch_req = 1'b0;
		ifetch_addr = '0;
		raw_cache_fault = 1'b0;
		rng_state = 32'd98;
		ack_count = 0;
		repeat (4) @(posedge clk);
		arst_n <= 1'b1;
		ifetch_addr <= 26'h2a51c3;
		raw_cache_fault <= 1'b1; // idle hides it
		@(negedge clk);
		check_field("idle cache_fault", status.cache_fault, 1'b0);
		check_field("idle mask_type", status.mask_type, mask_none);
		check_field("idle way_addr", cache_access.way_addr, 26'h2a51c3);

		@(posedge clk);
		raw_cache_fault <= 1'b0;
		exec_req[1].stack_addr <= 16'h1235; // offset 2 plus 3 words fits the lane
		exec_req[1].stack_size <= 3'd3;
		exec_req[1].stack_write <= 1'b1;
		exec_req[1].stack_req <= 1'b1;
		@(negedge clk);
		check_field("grant dependency_clear", status.dependency_clear, 4'b0010);
		check_field("single way_addr", cache_access.way_addr, 26'h1234);
		wait_ack(1'b0, 1, 8);
		check_field("single lru_enable_write", status.lru_enable_write, 1'b1);

		@(posedge clk);
		exec_req[1].stack_req <= 1'b0;
		exec_req[2].stack_addr <= 16'h00ad; // offset 6 plus 5 words spills over
		exec_req[2].stack_size <= 3'd5;
		exec_req[2].stack_req <= 1'b1;
		@(negedge clk);
		check_field("first use_multi_access", cache_access.use_multi_access, 1'b1);
		check_field("first way_addr", cache_access.way_addr, 26'h0ac);
		@(negedge clk);
		check_field("first mask_type", status.mask_type, mask_first);
		check_field("second way_addr", cache_access.way_addr, 26'h0b4);
		wait_ack(1'b0, 2, 8);
		check_field("second mask_type", status.mask_type, mask_second);

		@(posedge clk);
		exec_req[2].stack_req <= 1'b0;
		exec_req[3].stack_addr <= 16'h0040;
		exec_req[3].stack_size <= 3'd2;
		exec_req[3].stack_req <= 1'b1;
		raw_cache_fault <= 1'b1;
		repeat (2) @(negedge clk);
		check_field("fault cache_fault", status.cache_fault, 1'b1);
		check_field("fault executer_ack", status.executer_ack, 4'b0000);
		check_field("fault way_addr", cache_access.way_addr, 26'h040);
		@(posedge clk);
		raw_cache_fault <= 1'b0;
		wait_ack(1'b0, 3, 8);

		@(posedge clk);
		exec_req[3].stack_req <= 1'b0;
		exec_req[0].general_addr <= 32'hfc00_1234;
		exec_req[0].general_write <= 1'b1;
		exec_req[0].general_req <= 1'b1;
		raw_cache_fault <= 1'b1;
		wait_ack(1'b0, 0, 2); // bypass ends right after the grant
		check_field("io override", status.cache_no_write_override, 1'b1);
		check_field("io lru_enable_write", status.lru_enable_write, 1'b0);
		@(posedge clk);
		exec_req[0].general_req <= 1'b0;
		raw_cache_fault <= 1'b0;
		@(posedge clk);
		exec_req[0].general_addr <= 32'h0012_3456;
		exec_req[0].general_byte <= 1'b1;
		exec_req[0].general_req <= 1'b1;
		wait_ack(1'b0, 0, 8);
		check_field("cached lru_enable_write", status.lru_enable_write, 1'b1);
		check_field("cached override", status.cache_no_write_override, 1'b0);
		@(posedge clk);
		exec_req[0].general_req <= 1'b0;
		ifetch_req <= 1'b1;
		wait_ack(1'b1, 0, 8);
		@(posedge clk);
		ifetch_req <= 1'b0;

		repeat (3000) begin
			@(posedge clk);
			drive_random();
		end
		@(posedge clk);
		exec_req <= '0;
		ifetch_req <= 1'b0;
		raw_cache_fault <= 1'b0;
		@(negedge clk);
		if (ack_count < 200) begin
			$display("random run completed too few accesses: %0d", ack_count);
			$display("Test failed");
			$fatal(1, "too few accesses");
		end else begin
			$display("Test completed successfully");
			$finish;
		end
	end

endmodule

// ==== filelist.f ====
+incdir+dv
hdl/cache_ctrl_pkg.sv
hdl/access_arbiter.sv
hdl/access_sequencer.sv
hdl/way_address_select.sv
hdl/split_cache_controller.sv
dv/tb_split_cache_controller.sv

// ==== Makefile ====
# Verilator build of the split cache controller testbench

VERILATOR ?= verilator
TOP ?= tb_split_cache_controller
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing -Wno-fatal
EXTRA_FLAGS ?=

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard hdl/*.sv dv/*.sv dv/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VERILATOR_FLAGS) $(EXTRA_FLAGS) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -f $(FILELIST)

# the simulator exits non-zero on any failure
run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
